/* hw/rtab_pkg.sv */
`default_nettype none

package rtab_pkg;

    // Request address and cache line geometry
    localparam int RTAB_ADDR_W   = 32;
    localparam int RTAB_OFFSET_W = 6;
    localparam int RTAB_NLINE_W  = RTAB_ADDR_W - RTAB_OFFSET_W;

    // Low line-index bits that select an MSHR set
    localparam int RTAB_SET_W    = 4;

    // Requester tag carried along with each request
    localparam int RTAB_TAG_W    = 8;

    // One address word, seen whole or as line index plus offset
    typedef union packed {
        logic [RTAB_ADDR_W-1:0] raw;
        struct packed {
            logic [RTAB_NLINE_W-1:0]  nline;
            logic [RTAB_OFFSET_W-1:0] offset;
        } split;
    } rtab_addr_u;

endpackage

`default_nettype wire

/* hw/rtab_link_table.sv */
`default_nettype none

module rtab_link_table import rtab_pkg::*; #(
    parameter  int ENTRIES = 8,
    localparam int PTR_W   = $clog2(ENTRIES)
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                alloc_valid_i,
    input  logic                                alloc_link_i,
    input  rtab_addr_u                          alloc_addr_i,
    input  logic [RTAB_TAG_W-1:0]               alloc_tag_i,
    input  logic [RTAB_NLINE_W-1:0]             check_nline_i,
    input  logic [ENTRIES-1:0]                  pop_take_i,
    input  logic                                commit_i,
    input  logic [ENTRIES-1:0]                  commit_sel_i,
    input  logic [ENTRIES-1:0]                  rback_sel_i,
    output logic [ENTRIES-1:0]                  valid_o,
    output logic [ENTRIES-1:0]                  head_o,
    output logic [ENTRIES-1:0]                  tail_o,
    output logic [ENTRIES-1:0][PTR_W-1:0]       next_o,
    output logic [ENTRIES-1:0]                  free_sel_o,
    output rtab_addr_u [ENTRIES-1:0]            addr_o,
    output logic [ENTRIES-1:0][RTAB_TAG_W-1:0]  tag_o,
    output logic                                alloc_ready_o,
    output logic                                check_hit_o,
    output logic                                empty_o,
    output logic                                full_o
);

    logic [ENTRIES-1:0]                 valid_q;
    logic [ENTRIES-1:0]                 head_q;
    logic [ENTRIES-1:0]                 tail_q;
    logic [ENTRIES-1:0][PTR_W-1:0]      next_q;
    rtab_addr_u [ENTRIES-1:0]           addr_q;
    logic [ENTRIES-1:0][RTAB_TAG_W-1:0] tag_q;

    logic [ENTRIES-1:0] free;
    logic [ENTRIES-1:0] free_sel;
    logic [ENTRIES-1:0] alloc_sel;
    logic [ENTRIES-1:0] new_sel;
    logic [ENTRIES-1:0] link_sel;
    logic [ENTRIES-1:0] check_match;
    logic [ENTRIES-1:0] link_tail;
    logic [ENTRIES-1:0] commit_clr;
    logic [PTR_W-1:0]   free_idx;
    logic               alloc_fire;

    // Lowest free slot isolated as a one-hot vector
    assign free     = ~valid_q;
    assign free_sel = free & (~free + 1'b1);

    assign full_o        = &valid_q;
    assign empty_o       = ~|valid_q;
    assign alloc_ready_o = ~full_o;
    assign alloc_fire    = alloc_valid_i & alloc_ready_o;

    assign alloc_sel  = free_sel & {ENTRIES{alloc_fire}};
    assign new_sel    = alloc_sel & {ENTRIES{~alloc_link_i}};
    assign link_sel   = alloc_sel & {ENTRIES{alloc_link_i}};
    assign commit_clr = commit_sel_i & {ENTRIES{commit_i}};

    always_comb begin
        free_idx = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (free_sel[i]) begin
                free_idx = PTR_W'(i);
            end
        end
    end

    // Line compare against the check port and against the incoming request
    for (genvar i = 0; i < ENTRIES; i++) begin : g_match
        assign check_match[i] = valid_q[i] &&
                                (addr_q[i].split.nline == check_nline_i);
        assign link_tail[i]   = valid_q[i] && tail_q[i] &&
                                (addr_q[i].split.nline == alloc_addr_i.split.nline);
    end

    assign check_hit_o = |check_match;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            next_q  <= '0;
        end else begin
            valid_q <= (valid_q | alloc_sel) & ~commit_clr;
            // A popped head stays hidden until a rollback puts it back
            head_q  <= ((head_q & ~pop_take_i) | new_sel | rback_sel_i) & ~link_sel;
            // New entries always land on a tail and the old tail hands it over
            tail_q  <= (tail_q & ~(link_tail & {ENTRIES{|link_sel}})) | alloc_sel;
            for (int i = 0; i < ENTRIES; i++) begin
                if (|link_sel && link_tail[i]) begin
                    next_q[i] <= free_idx;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < ENTRIES; i++) begin
            if (alloc_sel[i]) begin
                addr_q[i] <= alloc_addr_i;
                tag_q[i]  <= alloc_tag_i;
            end
        end
    end

    assign valid_o    = valid_q;
    assign head_o     = head_q;
    assign tail_o     = tail_q;
    assign next_o     = next_q;
    assign free_sel_o = free_sel;
    assign addr_o     = addr_q;
    assign tag_o      = tag_q;

    assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(link_tail))
        else $error("rtab_link_table: several list tails match one line");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (alloc_fire && alloc_link_i) |-> |link_tail)
        else $error("rtab_link_table: link without an existing list for the line");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        commit_i |-> |(commit_sel_i & valid_q))
        else $error("rtab_link_table: commit of an invalid entry");

endmodule

`default_nettype wire

/* hw/rtab_dep_tracker.sv */
`default_nettype none

module rtab_dep_tracker import rtab_pkg::*; #(
    parameter int ENTRIES = 8
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic [ENTRIES-1:0]          valid_i,
    input  logic [ENTRIES-1:0]          head_i,
    input  logic [ENTRIES-1:0]          free_sel_i,
    input  logic                        alloc_fire_i,
    input  logic                        alloc_mshr_hit_i,
    input  logic                        alloc_mshr_full_i,
    input  rtab_addr_u [ENTRIES-1:0]    addr_i,
    input  logic [ENTRIES-1:0]          rback_sel_i,
    input  logic                        rback_mshr_hit_i,
    input  logic                        rback_mshr_full_i,
    input  logic                        refill_i,
    input  logic [RTAB_NLINE_W-1:0]     refill_nline_i,
    output logic [ENTRIES-1:0]          ready_o
);

    logic [ENTRIES-1:0] hit_q;
    logic [ENTRIES-1:0] full_q;
    logic [ENTRIES-1:0] alloc_sel;
    logic [ENTRIES-1:0] hit_set;
    logic [ENTRIES-1:0] full_set;
    logic [ENTRIES-1:0] hit_clr;
    logic [ENTRIES-1:0] full_clr;

    assign alloc_sel = free_sel_i & {ENTRIES{alloc_fire_i}};

    assign hit_set  = (alloc_sel & {ENTRIES{alloc_mshr_hit_i}}) |
                      (rback_sel_i & {ENTRIES{rback_mshr_hit_i}});
    assign full_set = (alloc_sel & {ENTRIES{alloc_mshr_full_i}}) |
                      (rback_sel_i & {ENTRIES{rback_mshr_full_i}});

    // Refill releases the whole line, and any entry waiting on its MSHR set
    for (genvar i = 0; i < ENTRIES; i++) begin : g_refill
        assign hit_clr[i]  = refill_i &&
            (addr_i[i].split.nline == refill_nline_i);
        assign full_clr[i] = refill_i &&
            (addr_i[i].split.nline[RTAB_SET_W-1:0] == refill_nline_i[RTAB_SET_W-1:0]);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hit_q  <= '0;
            full_q <= '0;
        end else begin
            hit_q  <= (hit_q & ~hit_clr) | hit_set;
            full_q <= (full_q & ~full_clr) | full_set;
        end
    end

    assign ready_o = valid_i & head_i & ~(hit_q | full_q);

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        |rback_sel_i |-> |(rback_sel_i & valid_i))
        else $error("rtab_dep_tracker: rollback of an invalid entry");

endmodule

`default_nettype wire

/* hw/rtab_rr_arbiter.sv */
`default_nettype none

module rtab_rr_arbiter #(
    parameter int ENTRIES = 8
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic [ENTRIES-1:0] req_i,
    input  logic               advance_i,
    output logic [ENTRIES-1:0] gnt_o
);

    // Thermometer mask of the entries at or after the pointer
    logic [ENTRIES-1:0] mask_q;
    logic [ENTRIES-1:0] req_hi;
    logic [ENTRIES-1:0] gnt_hi;
    logic [ENTRIES-1:0] gnt_lo;

    assign req_hi = req_i & mask_q;
    assign gnt_hi = req_hi & (~req_hi + 1'b1);
    assign gnt_lo = req_i & (~req_i + 1'b1);

    // Wrap to the lowest requester when nothing sits past the pointer
    assign gnt_o = (|req_hi) ? gnt_hi : gnt_lo;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '1;
        end else if (advance_i) begin
            // Only entries strictly above the grant stay in the mask
            mask_q <= ~(gnt_o | (gnt_o - 1'b1));
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni) advance_i |-> |gnt_o)
        else $error("rtab_rr_arbiter: advance without a granted requester");

endmodule

`default_nettype wire

/* hw/rtab_pop_ctrl.sv */
`default_nettype none

module rtab_pop_ctrl import rtab_pkg::*; #(
    parameter  int ENTRIES = 8,
    localparam int PTR_W   = $clog2(ENTRIES)
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic [ENTRIES-1:0]                  ready_i,
    input  logic [ENTRIES-1:0]                  tail_i,
    input  logic [ENTRIES-1:0][PTR_W-1:0]       next_i,
    input  rtab_addr_u [ENTRIES-1:0]            addr_i,
    input  logic [ENTRIES-1:0][RTAB_TAG_W-1:0]  tag_i,
    input  logic [ENTRIES-1:0]                  gnt_i,
    input  logic                                pop_ready_i,
    input  logic                                commit_i,
    input  logic [PTR_W-1:0]                    commit_ptr_i,
    input  logic                                rback_i,
    input  logic [PTR_W-1:0]                    rback_ptr_i,
    output logic                                advance_o,
    output logic                                pop_valid_o,
    output rtab_addr_u                          pop_addr_o,
    output logic [RTAB_TAG_W-1:0]               pop_tag_o,
    output logic [PTR_W-1:0]                    pop_ptr_o,
    output logic [ENTRIES-1:0]                  pop_take_o,
    output logic [ENTRIES-1:0]                  commit_sel_o,
    output logic [ENTRIES-1:0]                  rback_sel_o
);

    localparam logic [1:0] ST_HEAD      = 2'd0;
    localparam logic [1:0] ST_NEXT      = 2'd1;
    localparam logic [1:0] ST_NEXT_WAIT = 2'd2;

    localparam logic [ENTRIES-1:0] ONE = 1;

    logic [1:0]       state_q;
    logic [1:0]       state_d;
    logic [PTR_W-1:0] next_q;
    logic [PTR_W-1:0] next_d;
    logic [PTR_W-1:0] gnt_idx;
    logic             fire;

    always_comb begin
        gnt_idx = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (gnt_i[i]) begin
                gnt_idx = PTR_W'(i);
            end
        end
    end

    always_comb begin
        state_d     = state_q;
        next_d      = next_q;
        advance_o   = 1'b0;
        pop_valid_o = 1'b0;
        pop_ptr_o   = next_q;
        case (state_q)
            ST_HEAD: begin
                pop_valid_o = |ready_i;
                pop_ptr_o   = gnt_idx;
                if (pop_valid_o && pop_ready_i) begin
                    advance_o = 1'b1;
                    if (!tail_i[gnt_idx]) begin
                        state_d = ST_NEXT;
                        next_d  = next_i[gnt_idx];
                    end
                end
            end
            ST_NEXT: begin
                // Next entry of the list goes out together with the commit
                pop_valid_o = commit_i;
                if (rback_i) begin
                    state_d = ST_HEAD;
                end else if (commit_i && !pop_ready_i) begin
                    state_d = ST_NEXT_WAIT;
                end else if (commit_i) begin
                    if (tail_i[next_q]) begin
                        state_d = ST_HEAD;
                    end else begin
                        next_d = next_i[next_q];
                    end
                end
            end
            ST_NEXT_WAIT: begin
                pop_valid_o = 1'b1;
                if (pop_ready_i) begin
                    if (tail_i[next_q]) begin
                        state_d = ST_HEAD;
                    end else begin
                        state_d = ST_NEXT;
                        next_d  = next_i[next_q];
                    end
                end
            end
            default: begin
                state_d = ST_HEAD;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_HEAD;
            next_q  <= '0;
        end else begin
            state_q <= state_d;
            next_q  <= next_d;
        end
    end

    assign fire = pop_valid_o & pop_ready_i;

    assign pop_addr_o = addr_i[pop_ptr_o];
    assign pop_tag_o  = tag_i[pop_ptr_o];
    assign pop_take_o = (ONE << pop_ptr_o) & {ENTRIES{fire}};

    // Commit is qualified by commit_i in the link table
    assign commit_sel_o = ONE << commit_ptr_i;
    assign rback_sel_o  = (ONE << rback_ptr_i) & {ENTRIES{rback_i}};

    assert property (@(posedge clk_i) disable iff (!rst_ni) rback_i |-> !pop_ready_i)
        else $error("rtab_pop_ctrl: pop accepted during a rollback");

    assert property (@(posedge clk_i) disable iff (!rst_ni) fire |=> (commit_i || rback_i))
        else $error("rtab_pop_ctrl: accepted pop not followed by commit or rollback");

endmodule

`default_nettype wire

/* hw/rtab_top.sv */
`default_nettype none

module rtab_top import rtab_pkg::*; #(
    parameter  int ENTRIES = 8,
    localparam int PTR_W   = $clog2(ENTRIES)
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    alloc_valid_i,
    output logic                    alloc_ready_o,
    input  logic                    alloc_link_i,
    input  rtab_addr_u              alloc_addr_i,
    input  logic [RTAB_TAG_W-1:0]   alloc_tag_i,
    input  logic                    alloc_mshr_hit_i,
    input  logic                    alloc_mshr_full_i,
    input  logic [RTAB_NLINE_W-1:0] check_nline_i,
    output logic                    check_hit_o,
    output logic                    pop_valid_o,
    input  logic                    pop_ready_i,
    output rtab_addr_u              pop_addr_o,
    output logic [RTAB_TAG_W-1:0]   pop_tag_o,
    output logic [PTR_W-1:0]        pop_ptr_o,
    input  logic                    commit_i,
    input  logic [PTR_W-1:0]        commit_ptr_i,
    input  logic                    rback_i,
    input  logic [PTR_W-1:0]        rback_ptr_i,
    input  logic                    rback_mshr_hit_i,
    input  logic                    rback_mshr_full_i,
    input  logic                    refill_i,
    input  logic [RTAB_NLINE_W-1:0] refill_nline_i,
    output logic                    empty_o,
    output logic                    full_o
);

    logic [ENTRIES-1:0]                 valid;
    logic [ENTRIES-1:0]                 head;
    logic [ENTRIES-1:0]                 tail;
    logic [ENTRIES-1:0][PTR_W-1:0]      next;
    logic [ENTRIES-1:0]                 free_sel;
    rtab_addr_u [ENTRIES-1:0]           addr;
    logic [ENTRIES-1:0][RTAB_TAG_W-1:0] tag;
    logic [ENTRIES-1:0]                 ready;
    logic [ENTRIES-1:0]                 gnt;
    logic                               advance;
    logic [ENTRIES-1:0]                 pop_take;
    logic [ENTRIES-1:0]                 commit_sel;
    logic [ENTRIES-1:0]                 rback_sel;

    rtab_link_table #(
        .ENTRIES (ENTRIES)
    ) i_link_table (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .alloc_valid_i (alloc_valid_i),
        .alloc_link_i  (alloc_link_i),
        .alloc_addr_i  (alloc_addr_i),
        .alloc_tag_i   (alloc_tag_i),
        .check_nline_i (check_nline_i),
        .pop_take_i    (pop_take),
        .commit_i      (commit_i),
        .commit_sel_i  (commit_sel),
        .rback_sel_i   (rback_sel),
        .valid_o       (valid),
        .head_o        (head),
        .tail_o        (tail),
        .next_o        (next),
        .free_sel_o    (free_sel),
        .addr_o        (addr),
        .tag_o         (tag),
        .alloc_ready_o (alloc_ready_o),
        .check_hit_o   (check_hit_o),
        .empty_o       (empty_o),
        .full_o        (full_o)
    );

    // The free slot vector is empty when full, so valid alone qualifies the write
    rtab_dep_tracker #(
        .ENTRIES (ENTRIES)
    ) i_dep_tracker (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .valid_i           (valid),
        .head_i            (head),
        .free_sel_i        (free_sel),
        .alloc_fire_i      (alloc_valid_i),
        .alloc_mshr_hit_i  (alloc_mshr_hit_i),
        .alloc_mshr_full_i (alloc_mshr_full_i),
        .addr_i            (addr),
        .rback_sel_i       (rback_sel),
        .rback_mshr_hit_i  (rback_mshr_hit_i),
        .rback_mshr_full_i (rback_mshr_full_i),
        .refill_i          (refill_i),
        .refill_nline_i    (refill_nline_i),
        .ready_o           (ready)
    );

    rtab_rr_arbiter #(
        .ENTRIES (ENTRIES)
    ) i_arbiter (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .req_i     (ready),
        .advance_i (advance),
        .gnt_o     (gnt)
    );

    rtab_pop_ctrl #(
        .ENTRIES (ENTRIES)
    ) i_pop_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .ready_i      (ready),
        .tail_i       (tail),
        .next_i       (next),
        .addr_i       (addr),
        .tag_i        (tag),
        .gnt_i        (gnt),
        .pop_ready_i  (pop_ready_i),
        .commit_i     (commit_i),
        .commit_ptr_i (commit_ptr_i),
        .rback_i      (rback_i),
        .rback_ptr_i  (rback_ptr_i),
        .advance_o    (advance),
        .pop_valid_o  (pop_valid_o),
        .pop_addr_o   (pop_addr_o),
        .pop_tag_o    (pop_tag_o),
        .pop_ptr_o    (pop_ptr_o),
        .pop_take_o   (pop_take),
        .commit_sel_o (commit_sel),
        .rback_sel_o  (rback_sel)
    );

endmodule

`default_nettype wire

/* tb/tb_rtab.sv */
`default_nettype none

module tb_rtab
    import rtab_pkg::*;
();

    localparam int ENTRIES = 8;
    localparam int PTR_W   = $clog2(ENTRIES);
    localparam int TIMEOUT = 64;
    localparam int VEC_MAX = 64;

    logic                    clk_i;
    logic                    rst_ni;
    logic                    alloc_valid_i;
    logic                    alloc_ready_o;
    logic                    alloc_link_i;
    rtab_addr_u              alloc_addr_i;
    logic [RTAB_TAG_W-1:0]   alloc_tag_i;
    logic                    alloc_mshr_hit_i;
    logic                    alloc_mshr_full_i;
    logic [RTAB_NLINE_W-1:0] check_nline_i;
    logic                    check_hit_o;
    logic                    pop_valid_o;
    logic                    pop_ready_i;
    rtab_addr_u              pop_addr_o;
    logic [RTAB_TAG_W-1:0]   pop_tag_o;
    logic [PTR_W-1:0]        pop_ptr_o;
    logic                    commit_i;
    logic [PTR_W-1:0]        commit_ptr_i;
    logic                    rback_i;
    logic [PTR_W-1:0]        rback_ptr_i;
    logic                    rback_mshr_hit_i;
    logic                    rback_mshr_full_i;
    logic                    refill_i;
    logic [RTAB_NLINE_W-1:0] refill_nline_i;
    logic                    empty_o;
    logic                    full_o;

    // Each record holds op, a, addr, tag, b, c and d
    logic [59:0] vectors [0:VEC_MAX-1];

    // Commit or rollback owed one cycle after an accepted pop
    logic             pend_valid;
    logic             pend_rback;
    logic             pend_hit;
    logic             pend_full;
    logic [PTR_W-1:0] pend_ptr;

    // Slot model, filled lowest free slot first
    logic [ENTRIES-1:0]    slot_valid;
    logic [RTAB_TAG_W-1:0] slot_tag [0:ENTRIES-1];

    logic [31:0] lcg_state;
    int          error_count;

    rtab_top #(
        .ENTRIES (ENTRIES)
    ) i_rtab_top (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .alloc_valid_i     (alloc_valid_i),
        .alloc_ready_o     (alloc_ready_o),
        .alloc_link_i      (alloc_link_i),
        .alloc_addr_i      (alloc_addr_i),
        .alloc_tag_i       (alloc_tag_i),
        .alloc_mshr_hit_i  (alloc_mshr_hit_i),
        .alloc_mshr_full_i (alloc_mshr_full_i),
        .check_nline_i     (check_nline_i),
        .check_hit_o       (check_hit_o),
        .pop_valid_o       (pop_valid_o),
        .pop_ready_i       (pop_ready_i),
        .pop_addr_o        (pop_addr_o),
        .pop_tag_o         (pop_tag_o),
        .pop_ptr_o         (pop_ptr_o),
        .commit_i          (commit_i),
        .commit_ptr_i      (commit_ptr_i),
        .rback_i           (rback_i),
        .rback_ptr_i       (rback_ptr_i),
        .rback_mshr_hit_i  (rback_mshr_hit_i),
        .rback_mshr_full_i (rback_mshr_full_i),
        .refill_i          (refill_i),
        .refill_nline_i    (refill_nline_i),
        .empty_o           (empty_o),
        .full_o            (full_o)
    );

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        lcg_step = (s * 32'd1103515245 + 32'd12345) & 32'h7fff_ffff;
    endfunction

    task automatic stop_with_fail();
        error_count++;
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at time %0t: %s within %0d cycles", $time, what, TIMEOUT);
        stop_with_fail();
    endtask

    task automatic check_addr(input rtab_addr_u got, input rtab_addr_u exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s got %08h expected %08h",
                     $time, what, got.raw, exp.raw);
            stop_with_fail();
        end
    endtask

    task automatic check_tag(input logic [RTAB_TAG_W-1:0] got,
                             input logic [RTAB_TAG_W-1:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s got %02h expected %02h", $time, what, got, exp);
            stop_with_fail();
        end
    endtask

    task automatic check_ptr(input logic [PTR_W-1:0] got,
                             input logic [PTR_W-1:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s got %0d expected %0d", $time, what, got, exp);
            stop_with_fail();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s got %b expected %b", $time, what, got, exp);
            stop_with_fail();
        end
    endtask

    // Drive defaults just after the edge, plus any owed commit or rollback
    task automatic start_cycle();
        @(posedge clk_i);
        #1;
        // A commit driven in the last cycle took effect at this edge
        if (commit_i) begin
            slot_valid[commit_ptr_i] = 1'b0;
        end
        alloc_valid_i     = 1'b0;
        alloc_link_i      = 1'b0;
        alloc_mshr_hit_i  = 1'b0;
        alloc_mshr_full_i = 1'b0;
        refill_i          = 1'b0;
        pop_ready_i       = 1'b0;
        commit_i          = 1'b0;
        rback_i           = 1'b0;
        rback_mshr_hit_i  = 1'b0;
        rback_mshr_full_i = 1'b0;
        if (pend_valid) begin
            if (pend_rback) begin
                rback_i           = 1'b1;
                rback_ptr_i       = pend_ptr;
                rback_mshr_hit_i  = pend_hit;
                rback_mshr_full_i = pend_full;
            end else begin
                commit_i     = 1'b1;
                commit_ptr_i = pend_ptr;
            end
            pend_valid = 1'b0;
        end
    endtask

    task automatic alloc_request(input logic [59:0] rec);
        int   waited;
        logic accepted;
        int   free_slot;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted) begin
            if (waited == TIMEOUT) begin
                report_timeout("alloc_ready_o did not rise");
            end
            start_cycle();
            alloc_valid_i     = 1'b1;
            alloc_link_i      = rec[52];
            alloc_addr_i.raw  = rec[51:20];
            alloc_tag_i       = rec[19:12];
            alloc_mshr_hit_i  = rec[8];
            alloc_mshr_full_i = rec[4];
            @(negedge clk_i);
            accepted = alloc_ready_o;
            waited++;
        end
        // The request lands in the lowest free slot
        free_slot = 0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                free_slot = i;
            end
        end
        slot_valid[free_slot] = 1'b1;
        slot_tag[free_slot]   = rec[19:12];
    endtask

    task automatic check_line(input logic [59:0] rec);
        start_cycle();
        check_nline_i = rec[20 +: RTAB_NLINE_W];
        @(negedge clk_i);
        check_bit(check_hit_o, rec[52], "line check hit");
    endtask

    task automatic send_refill(input logic [59:0] rec);
        start_cycle();
        refill_i       = 1'b1;
        refill_nline_i = rec[20 +: RTAB_NLINE_W];
        @(negedge clk_i);
    endtask

    task automatic pop_and_check(input logic [59:0] rec);
        rtab_addr_u            exp_addr;
        logic [RTAB_TAG_W-1:0] exp_tag;
        logic [PTR_W-1:0]      exp_ptr;
        int                    waited;
        logic                  accepted;
        exp_addr.raw = rec[51:20];
        exp_tag      = rec[19:12];
        exp_ptr      = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (slot_valid[i] && slot_tag[i] == exp_tag) begin
                exp_ptr = PTR_W'(i);
            end
        end
        waited       = 0;
        accepted     = 1'b0;
        while (!accepted) begin
            if (waited == TIMEOUT) begin
                report_timeout("no pop was accepted");
            end
            start_cycle();
            // Random idle cycles on the pop side but none during a rollback
            lcg_state   = lcg_step(lcg_state);
            pop_ready_i = !rback_i && (lcg_state[17:16] != 2'b00);
            @(negedge clk_i);
            if (waited == 0 && rec[0]) begin
                check_bit(pop_valid_o, 1'b1, "pop valid in the commit cycle");
            end
            if (pop_valid_o && pop_ready_i) begin
                check_addr(pop_addr_o, exp_addr, "pop address");
                check_tag(pop_tag_o, exp_tag, "pop tag");
                check_ptr(pop_ptr_o, exp_ptr, "pop pointer");
                pend_valid = 1'b1;
                pend_rback = rec[52];
                pend_hit   = rec[8];
                pend_full  = rec[4];
                pend_ptr   = exp_ptr;
                accepted   = 1'b1;
            end
            waited++;
        end
    endtask

    task automatic idle_cycle(input logic [59:0] rec);
        start_cycle();
        @(negedge clk_i);
        check_bit(pop_valid_o, rec[52], "pop valid while idle");
    endtask

    task automatic check_status(input logic [59:0] rec);
        start_cycle();
        @(negedge clk_i);
        check_bit(empty_o, rec[52], "empty flag");
        check_bit(full_o, rec[8], "full flag");
        check_bit(alloc_ready_o, ~rec[8], "alloc ready");
    endtask

    initial begin
        logic [59:0] rec;
        int          idx;
        logic        done;
        clk_i             = 1'b0;
        rst_ni            = 1'b0;
        alloc_valid_i     = 1'b0;
        alloc_link_i      = 1'b0;
        alloc_addr_i      = '0;
        alloc_tag_i       = '0;
        alloc_mshr_hit_i  = 1'b0;
        alloc_mshr_full_i = 1'b0;
        check_nline_i     = '0;
        pop_ready_i       = 1'b0;
        commit_i          = 1'b0;
        commit_ptr_i      = '0;
        rback_i           = 1'b0;
        rback_ptr_i       = '0;
        rback_mshr_hit_i  = 1'b0;
        rback_mshr_full_i = 1'b0;
        refill_i          = 1'b0;
        refill_nline_i    = '0;
        pend_valid        = 1'b0;
        pend_rback        = 1'b0;
        pend_hit          = 1'b0;
        pend_full         = 1'b0;
        pend_ptr          = '0;
        slot_valid        = '0;
        lcg_state         = 32'd20690;
        error_count       = 0;
        $readmemh("tb/rtab_vectors.txt", vectors);

        repeat (4) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        idx  = 0;
        done = 1'b0;
        while (!done) begin
            if (idx == VEC_MAX) begin
                $display("Vector list has no end record");
                stop_with_fail();
            end
            rec = vectors[idx];
            if ($isunknown(rec)) begin
                $display("Vector record %0d could not be read", idx);
                stop_with_fail();
            end
            case (rec[59:56])
                4'h0: done = 1'b1;
                4'h1: alloc_request(rec);
                4'h2: check_line(rec);
                4'h3: send_refill(rec);
                4'h4: pop_and_check(rec);
                4'h5: idle_cycle(rec);
                4'h6: check_status(rec);
                default: begin
                    $display("Vector record %0d has an unknown operation", idx);
                    stop_with_fail();
                end
            endcase
            idx++;
        end

        // Finish a commit owed by the last pop
        if (pend_valid) begin
            start_cycle();
            @(negedge clk_i);
        end

        if (error_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "simulation ended with errors");
        end
    end

endmodule

`default_nettype wire

/* tb/rtab_vectors.txt */
// Columns: op _ a _ addr _ tag _ b _ c _ d, ops 1 ALLOC(a link, b hit, c full) 2 CHECK(a hit)
// 3 REFILL, 4 POP(a rollback, b/c new deps, d valid at once), 5 IDLE(a valid), 6 EXPECT_EMPTY, 0 end
6_1_00000000_00_0_0_0
1_0_00001040_10_0_0_0
1_1_00001048_11_0_0_0
2_1_00000041_00_0_0_0
2_0_00000082_00_0_0_0
4_0_00001040_10_0_0_0
4_0_00001048_11_0_0_1
5_0_00000000_00_0_0_0
2_0_00000041_00_0_0_0
// MSHR hit and MSHR full dependencies
1_0_00002080_20_1_0_0
1_0_00003400_21_0_1_0
1_0_00004000_22_0_0_0
4_0_00004000_22_0_0_0
5_0_00000000_00_0_0_0
3_0_00000082_00_0_0_0
4_0_00002080_20_0_0_0
5_0_00000000_00_0_0_0
3_0_00000150_00_0_0_0
4_0_00003400_21_0_0_0
// Rollback with a new line dependency
1_0_00006000_30_0_0_0
1_1_00006010_31_0_0_0
4_1_00006000_30_1_0_0
5_0_00000000_00_0_0_0
5_0_00000000_00_0_0_0
3_0_00000180_00_0_0_0
4_0_00006000_30_0_0_0
4_0_00006010_31_0_0_1
// Fill the table, then round-robin over the list heads
1_0_00007000_40_0_0_0
1_0_00007040_41_0_0_0
1_0_00007080_42_0_0_0
1_1_00007044_43_0_0_0
1_0_000070C0_44_0_0_0
1_1_00007048_45_0_0_0
1_0_00007100_46_0_0_0
1_1_00007104_47_0_0_0
6_0_00000000_00_1_0_0
4_0_00007040_41_0_0_0
4_0_00007044_43_0_0_1
4_0_00007048_45_0_0_1
4_0_00007080_42_0_0_1
4_0_000070C0_44_0_0_1
4_0_00007100_46_0_0_1
4_0_00007104_47_0_0_1
4_0_00007000_40_0_0_1
5_0_00000000_00_0_0_0
6_1_00000000_00_0_0_0
0_0_00000000_00_0_0_0

/* files.f */
hw/rtab_pkg.sv
hw/rtab_link_table.sv
hw/rtab_dep_tracker.sv
hw/rtab_rr_arbiter.sv
hw/rtab_pop_ctrl.sv
hw/rtab_top.sv
tb/tb_rtab.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rtab
FILES     ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILES) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILES) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
